//--- udp_macros.svh
// UDP block constants
// Header sizes, the IP protocol number for UDP and the width of one
// stream beat. Shared by the package and the receive and transmit paths.

`ifndef UDP_MACROS_SVH
`define UDP_MACROS_SVH

// UDP header length in bytes
`define UDP_HDR_BYTES 8

// Plain IP header without options
`define IP_HDR_BYTES 20

// IP protocol number of UDP
`define IP_PROTO_UDP 8'h11

// One byte per stream beat
`define BYTE_W 8

`endif

//--- udp_pkg.sv
// UDP block types
// Frame metadata, the UDP header in its field and byte views, and the
// byte stream beat that travels beside a valid/ready pair.

package udp_pkg;

`include "udp_macros.svh"

  // Ethernet and IP fields that travel with a frame, 216 bits
  typedef struct packed {
    logic [47:0] eth_dest_mac;
    logic [47:0] eth_src_mac;
    logic [15:0] eth_type;
    logic [5:0]  ip_dscp;
    logic [1:0]  ip_ecn;
    logic [7:0]  ip_ttl;
    logic [7:0]  ip_protocol;
    logic [15:0] ip_length;
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;
  } ip_meta_t;

  // UDP header fields in wire order
  typedef struct packed {
    logic [15:0] source_port;
    logic [15:0] dest_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_fields_t;

  // Same header word seen as fields or as bytes
  // bytes[0] is the first byte on the wire
  typedef union packed {
    udp_fields_t fields;
    logic [0:`UDP_HDR_BYTES-1][`BYTE_W-1:0] bytes;
  } udp_hdr_u;

  // One stream beat without its handshake
  typedef struct packed {
    logic [`BYTE_W-1:0] data;
    logic               last;
    logic               user;
  } axis_beat_t;

endpackage

//--- udp_ip_rx.sv
// UDP receive path
// Takes the first eight bytes of an IP payload as the UDP header, presents
// them with the frame metadata and forwards the remaining bytes, cut to the
// length the header declares. Frames ending inside the header or before
// the declared length are flagged on the two error pulses.

`timescale 1ns/10ps
`include "udp_macros.svh"

module udp_ip_rx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 s_ip_hdr_valid,
  output logic                 s_ip_hdr_ready,
  input  udp_pkg::ip_meta_t    s_ip_meta,
  input  udp_pkg::axis_beat_t  s_ip_payload,
  input  logic                 s_ip_payload_valid,
  output logic                 s_ip_payload_ready,
  output logic                 m_udp_hdr_valid,
  input  logic                 m_udp_hdr_ready,
  output udp_pkg::ip_meta_t    m_udp_meta,
  output udp_pkg::udp_fields_t m_udp_hdr,
  output udp_pkg::axis_beat_t  m_udp_payload,
  output logic                 m_udp_payload_valid,
  input  logic                 m_udp_payload_ready,
  output logic                 busy,
  output logic                 error_header_early_termination,
  output logic                 error_payload_early_termination
);

  import udp_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD,
    ST_DISCARD
  } state_t;

  state_t      state;
  logic [2:0]  hdr_cnt;
  logic [15:0] remain;
  udp_hdr_u    hdr;
  udp_hdr_u    hdr_shift;
  ip_meta_t    meta;
  logic        in_xfer;
  logic        last_byte;

  assign s_ip_hdr_ready = (state == ST_IDLE);
  assign busy           = (state != ST_IDLE);
  assign m_udp_meta     = meta;
  assign m_udp_hdr      = hdr.fields;

  assign in_xfer   = s_ip_payload_valid && s_ip_payload_ready;
  assign last_byte = (remain == 16'd1);

  // Header word with the incoming byte shifted in at the end
  assign hdr_shift = {hdr.bytes[1:`UDP_HDR_BYTES-1], s_ip_payload.data};

  always_comb begin
    s_ip_payload_ready  = 1'b0;
    m_udp_payload_valid = 1'b0;
    m_udp_payload.data  = s_ip_payload.data;
    m_udp_payload.last  = s_ip_payload.last || last_byte;
    // Short frame marks its final beat as bad
    m_udp_payload.user  = s_ip_payload.user || (s_ip_payload.last && !last_byte);
    case (state)
      ST_HEADER: begin
        s_ip_payload_ready = 1'b1;
      end
      ST_PAYLOAD: begin
        // Held off until the header has been taken
        s_ip_payload_ready  = m_udp_payload_ready && !m_udp_hdr_valid;
        m_udp_payload_valid = s_ip_payload_valid && !m_udp_hdr_valid;
      end
      ST_DISCARD: begin
        s_ip_payload_ready = !m_udp_hdr_valid;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state                           <= ST_IDLE;
      hdr_cnt                         <= '0;
      remain                          <= '0;
      m_udp_hdr_valid                 <= 1'b0;
      error_header_early_termination  <= 1'b0;
      error_payload_early_termination <= 1'b0;
    end else begin
      error_header_early_termination  <= 1'b0;
      error_payload_early_termination <= 1'b0;
      if (m_udp_hdr_valid && m_udp_hdr_ready) begin
        m_udp_hdr_valid <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (s_ip_hdr_valid) begin
            hdr_cnt <= '0;
            state   <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (in_xfer) begin
            hdr_cnt <= hdr_cnt + 3'd1;
            if (s_ip_payload.last) begin
              error_header_early_termination <= 1'b1;
              state                          <= ST_IDLE;
            end else if (hdr_cnt == 3'(`UDP_HDR_BYTES - 1)) begin
              m_udp_hdr_valid <= 1'b1;
              remain          <= hdr_shift.fields.length - 16'(`UDP_HDR_BYTES);
              // No payload declared, drop whatever follows
              if (hdr_shift.fields.length > 16'(`UDP_HDR_BYTES)) begin
                state <= ST_PAYLOAD;
              end else begin
                state <= ST_DISCARD;
              end
            end
          end
        end
        ST_PAYLOAD: begin
          if (in_xfer) begin
            remain <= remain - 16'd1;
            if (s_ip_payload.last) begin
              error_payload_early_termination <= !last_byte;
              state                           <= ST_IDLE;
            end else if (last_byte) begin
              state <= ST_DISCARD;
            end
          end
        end
        ST_DISCARD: begin
          if (in_xfer && s_ip_payload.last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_ip_hdr_valid && s_ip_hdr_ready) begin
      meta <= s_ip_meta;
    end
    if (state == ST_HEADER && in_xfer) begin
      hdr <= hdr_shift;
    end
  end

endmodule

//--- udp_ip_tx.sv
// UDP transmit path
// Turns UDP frame metadata into IP metadata with the length grown by the
// IP header and the protocol set to UDP, then sends the eight UDP header
// bytes ahead of the user payload. Flags frames for the RoCE port.

`timescale 1ns/10ps
`include "udp_macros.svh"

module udp_ip_tx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 s_udp_hdr_valid,
  output logic                 s_udp_hdr_ready,
  input  udp_pkg::ip_meta_t    s_udp_meta,
  input  udp_pkg::udp_fields_t s_udp_hdr,
  input  udp_pkg::axis_beat_t  s_udp_payload,
  input  logic                 s_udp_payload_valid,
  output logic                 s_udp_payload_ready,
  output logic                 m_ip_hdr_valid,
  input  logic                 m_ip_hdr_ready,
  output udp_pkg::ip_meta_t    m_ip_meta,
  output logic                 is_roce,
  output udp_pkg::axis_beat_t  m_ip_payload,
  output logic                 m_ip_payload_valid,
  input  logic                 m_ip_payload_ready,
  input  logic [15:0]          roce_udp_port,
  output logic                 busy
);

  import udp_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_IP_HDR,
    ST_UDP_HDR,
    ST_PAYLOAD
  } state_t;

  state_t     state;
  logic [2:0] byte_cnt;
  udp_hdr_u   hdr;
  ip_meta_t   meta;
  ip_meta_t   meta_next;
  logic       roce;
  logic       hdr_accept;
  logic       out_xfer;

  assign s_udp_hdr_ready = (state == ST_IDLE);
  assign hdr_accept      = s_udp_hdr_valid && s_udp_hdr_ready;
  assign out_xfer        = m_ip_payload_valid && m_ip_payload_ready;
  assign m_ip_hdr_valid  = (state == ST_IP_HDR);
  assign m_ip_meta       = meta;
  assign is_roce         = roce;
  assign busy            = (state != ST_IDLE);

  // IP length covers the UDP datagram plus the IP header
  always_comb begin
    meta_next             = s_udp_meta;
    meta_next.ip_length   = s_udp_hdr.length + 16'(`IP_HDR_BYTES);
    meta_next.ip_protocol = `IP_PROTO_UDP;
  end

  always_comb begin
    m_ip_payload        = s_udp_payload;
    m_ip_payload_valid  = 1'b0;
    s_udp_payload_ready = 1'b0;
    case (state)
      ST_UDP_HDR: begin
        m_ip_payload.data  = hdr.bytes[byte_cnt];
        m_ip_payload.last  = 1'b0;
        m_ip_payload.user  = 1'b0;
        m_ip_payload_valid = 1'b1;
      end
      ST_PAYLOAD: begin
        m_ip_payload_valid  = s_udp_payload_valid;
        s_udp_payload_ready = m_ip_payload_ready;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (hdr_accept) begin
            state <= ST_IP_HDR;
          end
        end
        ST_IP_HDR: begin
          if (m_ip_hdr_ready) begin
            byte_cnt <= '0;
            state    <= ST_UDP_HDR;
          end
        end
        ST_UDP_HDR: begin
          if (out_xfer) begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'(`UDP_HDR_BYTES - 1)) begin
              state <= ST_PAYLOAD;
            end
          end
        end
        ST_PAYLOAD: begin
          if (out_xfer && m_ip_payload.last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_accept) begin
      meta       <= meta_next;
      hdr.fields <= s_udp_hdr;
      roce       <= (s_udp_hdr.dest_port == roce_udp_port);
    end
  end

endmodule

//--- udp_complete.sv
// UDP block top level
// Receive and transmit paths side by side under one clock and reset.
// The RoCE port setting is used by the transmit path only.

`timescale 1ns/10ps

module udp_complete (
  input  logic                 clk,
  input  logic                 arst_n,
  // IP frames in, UDP frames out
  input  logic                 s_ip_hdr_valid,
  output logic                 s_ip_hdr_ready,
  input  udp_pkg::ip_meta_t    s_ip_meta,
  input  udp_pkg::axis_beat_t  s_ip_payload,
  input  logic                 s_ip_payload_valid,
  output logic                 s_ip_payload_ready,
  output logic                 m_udp_hdr_valid,
  input  logic                 m_udp_hdr_ready,
  output udp_pkg::ip_meta_t    m_udp_meta,
  output udp_pkg::udp_fields_t m_udp_hdr,
  output udp_pkg::axis_beat_t  m_udp_payload,
  output logic                 m_udp_payload_valid,
  input  logic                 m_udp_payload_ready,
  // UDP frames in, IP frames out
  input  logic                 s_udp_hdr_valid,
  output logic                 s_udp_hdr_ready,
  input  udp_pkg::ip_meta_t    s_udp_meta,
  input  udp_pkg::udp_fields_t s_udp_hdr,
  input  udp_pkg::axis_beat_t  s_udp_payload,
  input  logic                 s_udp_payload_valid,
  output logic                 s_udp_payload_ready,
  output logic                 m_ip_hdr_valid,
  input  logic                 m_ip_hdr_ready,
  output udp_pkg::ip_meta_t    m_ip_meta,
  output logic                 is_roce,
  output udp_pkg::axis_beat_t  m_ip_payload,
  output logic                 m_ip_payload_valid,
  input  logic                 m_ip_payload_ready,
  // Status and config
  input  logic [15:0]          roce_udp_port,
  output logic                 rx_busy,
  output logic                 tx_busy,
  output logic                 rx_error_header_early_termination,
  output logic                 rx_error_payload_early_termination
);

  udp_ip_rx i_rx (
    .clk                             (clk),
    .arst_n                          (arst_n),
    .s_ip_hdr_valid                  (s_ip_hdr_valid),
    .s_ip_hdr_ready                  (s_ip_hdr_ready),
    .s_ip_meta                       (s_ip_meta),
    .s_ip_payload                    (s_ip_payload),
    .s_ip_payload_valid              (s_ip_payload_valid),
    .s_ip_payload_ready              (s_ip_payload_ready),
    .m_udp_hdr_valid                 (m_udp_hdr_valid),
    .m_udp_hdr_ready                 (m_udp_hdr_ready),
    .m_udp_meta                      (m_udp_meta),
    .m_udp_hdr                       (m_udp_hdr),
    .m_udp_payload                   (m_udp_payload),
    .m_udp_payload_valid             (m_udp_payload_valid),
    .m_udp_payload_ready             (m_udp_payload_ready),
    .busy                            (rx_busy),
    .error_header_early_termination  (rx_error_header_early_termination),
    .error_payload_early_termination (rx_error_payload_early_termination)
  );

  udp_ip_tx i_tx (
    .clk                 (clk),
    .arst_n              (arst_n),
    .s_udp_hdr_valid     (s_udp_hdr_valid),
    .s_udp_hdr_ready     (s_udp_hdr_ready),
    .s_udp_meta          (s_udp_meta),
    .s_udp_hdr           (s_udp_hdr),
    .s_udp_payload       (s_udp_payload),
    .s_udp_payload_valid (s_udp_payload_valid),
    .s_udp_payload_ready (s_udp_payload_ready),
    .m_ip_hdr_valid      (m_ip_hdr_valid),
    .m_ip_hdr_ready      (m_ip_hdr_ready),
    .m_ip_meta           (m_ip_meta),
    .is_roce             (is_roce),
    .m_ip_payload        (m_ip_payload),
    .m_ip_payload_valid  (m_ip_payload_valid),
    .m_ip_payload_ready  (m_ip_payload_ready),
    .roce_udp_port       (roce_udp_port),
    .busy                (tx_busy)
  );

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset
// 8 ns clock, reset held low for the first five cycles

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  initial begin
    arst_n = 1'b0;
    repeat (5) begin
      @(posedge clk);
    end
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- tb_udp.sv
// UDP block testbench
// Directed tests of the receive and transmit paths: header parsing, length
// trimming, early termination, header building, the RoCE flag, and the
// same frames again under random gaps and back-pressure.

`timescale 1ns/10ps
`include "udp_macros.svh"

module tb_udp;

  import udp_pkg::*;

  typedef logic [215:0] word_t;

  localparam int          CLK_NS    = 8;
  localparam logic [15:0] ROCE_PORT = 16'd4791;
  // RX input bytes, TX output bytes and header handshakes of all tests
  localparam int TOTAL_BEATS = (20 + 16 + 13 + 5 + 20) + (17 + 13 + 17) + 8;

  logic        clk;
  logic        arst_n;
  logic        s_ip_hdr_valid, s_ip_hdr_ready, s_ip_payload_valid, s_ip_payload_ready;
  logic        m_udp_hdr_valid, m_udp_hdr_ready, m_udp_payload_valid, m_udp_payload_ready;
  logic        s_udp_hdr_valid, s_udp_hdr_ready, s_udp_payload_valid, s_udp_payload_ready;
  logic        m_ip_hdr_valid, m_ip_hdr_ready, m_ip_payload_valid, m_ip_payload_ready;
  ip_meta_t    s_ip_meta, m_udp_meta, s_udp_meta, m_ip_meta;
  axis_beat_t  s_ip_payload, m_udp_payload, s_udp_payload, m_ip_payload;
  udp_fields_t m_udp_hdr, s_udp_hdr;
  logic        is_roce, rx_busy, tx_busy;
  logic        rx_error_header_early_termination, rx_error_payload_early_termination;
  logic [15:0] roce_udp_port;

  logic [31:0] lfsr = 32'hb1c7;
  bit          gaps = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          hdr_err_cnt = 0;
  int          pay_err_cnt = 0;
  ip_meta_t    rx_meta_q[$];
  ip_meta_t    tx_meta_q[$];
  udp_fields_t rx_hdr_q[$];
  logic        tx_roce_q[$];
  axis_beat_t  rx_pay_q[$];
  axis_beat_t  tx_pay_q[$];

  tb_clk_gen i_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  udp_complete i_dut (.*);

  // Galois LFSR, one step per bit handed out
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'ha3000000;
    end
    return b;
  endfunction

  function automatic word_t lfsr_word(input int nbits);
    word_t w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[214:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic compare_value(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // Output readies, random only while back-pressure is on
  initial begin
    m_udp_hdr_ready     = 1'b1;
    m_udp_payload_ready = 1'b1;
    m_ip_hdr_ready      = 1'b1;
    m_ip_payload_ready  = 1'b1;
    forever begin
      @(negedge clk);
      m_udp_hdr_ready     = !gaps || lfsr_bit();
      m_udp_payload_ready = !gaps || lfsr_bit();
      m_ip_hdr_ready      = !gaps || lfsr_bit();
      m_ip_payload_ready  = !gaps || lfsr_bit();
    end
  end

  // Output monitor, one entry per completed transfer
  always @(posedge clk) begin
    if (m_udp_hdr_valid && m_udp_hdr_ready) begin
      rx_meta_q.push_back(m_udp_meta);
      rx_hdr_q.push_back(m_udp_hdr);
    end
    if (m_udp_payload_valid && m_udp_payload_ready) begin
      rx_pay_q.push_back(m_udp_payload);
    end
    if (m_ip_hdr_valid && m_ip_hdr_ready) begin
      tx_meta_q.push_back(m_ip_meta);
      tx_roce_q.push_back(is_roce);
    end
    if (m_ip_payload_valid && m_ip_payload_ready) begin
      tx_pay_q.push_back(m_ip_payload);
    end
    hdr_err_cnt += int'(rx_error_header_early_termination);
    pay_err_cnt += int'(rx_error_payload_early_termination);
  end

  task automatic send_rx_beat(input logic [7:0] data, input logic last);
    while (gaps && lfsr_bit()) begin
      s_ip_payload_valid = 1'b0;
      @(negedge clk);
    end
    s_ip_payload       = {data, last, 1'b0};
    s_ip_payload_valid = 1'b1;
    @(posedge clk);
    while (!s_ip_payload_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic send_tx_beat(input logic [7:0] data, input logic last);
    while (gaps && lfsr_bit()) begin
      s_udp_payload_valid = 1'b0;
      @(negedge clk);
    end
    s_udp_payload       = {data, last, 1'b0};
    s_udp_payload_valid = 1'b1;
    @(posedge clk);
    while (!s_udp_payload_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Error pulses come one cycle after the last beat, hence the extra edge
  task automatic wait_idle();
    @(negedge clk);
    while (rx_busy || tx_busy) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic reset_state_test();
    compare_value("valid outputs after reset",
                  word_t'({m_udp_hdr_valid, m_udp_payload_valid, m_ip_hdr_valid,
                           m_ip_payload_valid}), '0);
    compare_value("busy outputs after reset", word_t'({rx_busy, tx_busy}), '0);
    compare_value("error pulses after reset",
                  word_t'({rx_error_header_early_termination,
                           rx_error_payload_early_termination}), '0);
    compare_value("header ready outputs after reset",
                  word_t'({s_ip_hdr_ready, s_udp_hdr_ready}), word_t'(2'b11));
  endtask

  // IP frame of total payload bytes whose UDP header declares n data bytes
  task automatic rx_frame_test(input int n, input int total);
    logic [7:0]  b[$];
    ip_meta_t    meta;
    udp_fields_t exp_hdr;
    logic        short_frame;
    logic        end_beat;
    int          n_out;
    int          hdr_err0;
    int          pay_err0;
    meta = lfsr_word(216);
    for (int i = 0; i < ((total > 8) ? total : 8); i++) begin
      b.push_back(8'(lfsr_word(8)));
    end
    // Length field is wire bytes 4 and 5, high byte first
    b[4]        = 8'((n + `UDP_HDR_BYTES) >> 8);
    b[5]        = 8'(n + `UDP_HDR_BYTES);
    exp_hdr     = {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
    short_frame = (total - 8) < n;
    n_out       = short_frame ? total - 8 : n;
    hdr_err0    = hdr_err_cnt;
    pay_err0    = pay_err_cnt;
    rx_meta_q.delete();
    rx_hdr_q.delete();
    rx_pay_q.delete();
    while (gaps && lfsr_bit()) begin
      @(negedge clk);
    end
    s_ip_meta      = meta;
    s_ip_hdr_valid = 1'b1;
    @(posedge clk);
    while (!s_ip_hdr_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    s_ip_hdr_valid = 1'b0;
    for (int i = 0; i < total; i++) begin
      send_rx_beat(b[i], i == total - 1);
    end
    s_ip_payload_valid = 1'b0;
    wait_idle();
    if (total <= 8) begin
      compare_value("rx UDP header count", word_t'(rx_hdr_q.size()), '0);
      compare_value("rx payload beat count", word_t'(rx_pay_q.size()), '0);
      compare_value("rx_error_header_early_termination pulses",
                    word_t'(hdr_err_cnt - hdr_err0), word_t'(1));
      compare_value("rx_error_payload_early_termination pulses",
                    word_t'(pay_err_cnt - pay_err0), '0);
    end else begin
      compare_value("rx UDP header count", word_t'(rx_hdr_q.size()), word_t'(1));
      if (rx_hdr_q.size() == 1) begin
        compare_value("m_udp_hdr", word_t'(rx_hdr_q[0]), word_t'(exp_hdr));
        compare_value("m_udp_meta", word_t'(rx_meta_q[0]), word_t'(meta));
      end
      compare_value("rx payload beat count", word_t'(rx_pay_q.size()), word_t'(n_out));
      for (int i = 0; i < n_out && i < rx_pay_q.size(); i++) begin
        end_beat = (i == n_out - 1);
        compare_value("m_udp_payload", word_t'(rx_pay_q[i]),
                      word_t'({b[8 + i], end_beat, short_frame && end_beat}));
      end
      compare_value("rx_error_payload_early_termination pulses",
                    word_t'(pay_err_cnt - pay_err0), word_t'(short_frame));
      compare_value("rx_error_header_early_termination pulses",
                    word_t'(hdr_err_cnt - hdr_err0), '0);
    end
  endtask

  // UDP frame with n payload bytes sent to dport
  task automatic tx_frame_test(input int n, input logic [15:0] dport);
    logic [7:0]  p[$];
    logic [63:0] hw;
    logic [7:0]  exp_data;
    ip_meta_t    meta;
    ip_meta_t    exp_meta;
    udp_fields_t hdr;
    meta          = lfsr_word(216);
    hdr           = 64'(lfsr_word(64));
    hdr.dest_port = dport;
    hdr.length    = 16'(n + `UDP_HDR_BYTES);
    hw            = hdr;
    exp_meta             = meta;
    exp_meta.ip_length   = 16'(n + `UDP_HDR_BYTES + `IP_HDR_BYTES);
    exp_meta.ip_protocol = 8'd17;
    for (int i = 0; i < n; i++) begin
      p.push_back(8'(lfsr_word(8)));
    end
    tx_meta_q.delete();
    tx_roce_q.delete();
    tx_pay_q.delete();
    while (gaps && lfsr_bit()) begin
      @(negedge clk);
    end
    s_udp_meta      = meta;
    s_udp_hdr       = hdr;
    s_udp_hdr_valid = 1'b1;
    @(posedge clk);
    while (!s_udp_hdr_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    s_udp_hdr_valid = 1'b0;
    for (int i = 0; i < n; i++) begin
      send_tx_beat(p[i], i == n - 1);
    end
    s_udp_payload_valid = 1'b0;
    wait_idle();
    compare_value("tx IP header count", word_t'(tx_meta_q.size()), word_t'(1));
    if (tx_meta_q.size() == 1) begin
      compare_value("m_ip_meta", word_t'(tx_meta_q[0]), word_t'(exp_meta));
      compare_value("is_roce", word_t'(tx_roce_q[0]), word_t'(dport == ROCE_PORT));
    end
    compare_value("tx payload beat count", word_t'(tx_pay_q.size()), word_t'(n + 8));
    for (int i = 0; i < n + 8 && i < tx_pay_q.size(); i++) begin
      // Header goes out first, most significant byte leading
      exp_data = (i < 8) ? 8'(hw >> (56 - 8 * i)) : p[i - 8];
      compare_value("m_ip_payload", word_t'(tx_pay_q[i]),
                    word_t'({exp_data, i == n + 7, 1'b0}));
    end
  endtask

  initial begin
    #(TOTAL_BEATS * 20 * CLK_NS + 400);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    s_ip_hdr_valid      = 1'b0;
    s_ip_meta           = '0;
    s_ip_payload        = '0;
    s_ip_payload_valid  = 1'b0;
    s_udp_hdr_valid     = 1'b0;
    s_udp_meta          = '0;
    s_udp_hdr           = '0;
    s_udp_payload       = '0;
    s_udp_payload_valid = 1'b0;
    roce_udp_port       = ROCE_PORT;
    @(posedge arst_n);
    @(negedge clk);
    reset_state_test();
    rx_frame_test(12, 20);
    rx_frame_test(6, 16);
    rx_frame_test(10, 13);
    rx_frame_test(4, 5);
    tx_frame_test(9, 16'd1234);
    tx_frame_test(5, ROCE_PORT);
    // Same frames with gaps on every input valid and output ready
    gaps = 1'b1;
    rx_frame_test(12, 20);
    tx_frame_test(9, 16'd1234);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
udp_pkg.sv
udp_ip_rx.sv
udp_ip_tx.sv
udp_complete.sv
tb_clk_gen.sv
tb_udp.sv

//--- Makefile
# Verilator build and run of the UDP block testbench

VERILATOR ?= verilator
TOP       ?= tb_udp
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(wildcard *.sv *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
